// File: hw/qla_pkg.sv
package qla_pkg;

    // ----------------------------------------
    // sizes and types
    // ----------------------------------------
    localparam int NUM_AXES  = 4;
    localparam int ENC_WIDTH = 24;

    typedef logic [15:0]          addr_t;
    typedef logic [31:0]          data_t;
    typedef logic [15:0]          dac_t;          // offset binary, midscale = zero current
    typedef logic [ENC_WIDTH-1:0] enc_count_t;

    // address bits 15..12
    typedef enum logic [3:0] {
        ADDR_MAIN     = 4'h0,
        ADDR_HUB      = 4'h1,                     // not mapped in this core
        ADDR_PROM     = 4'h2,
        ADDR_PROM_QLA = 4'h3,
        ADDR_ETH      = 4'h4,
        ADDR_FW       = 4'h5,
        ADDR_DS       = 4'h6,
        ADDR_DATA_BUF = 4'h8
    } addr_space_e;

    // address bits 3..0 inside an axis channel
    typedef enum logic [3:0] {
        OFF_ADC_DATA  = 4'h0,                     // current feedback
        OFF_DAC_CTRL  = 4'h1,
        OFF_ENC_LOAD  = 4'h2,
        OFF_ENC_DATA  = 4'h5,
        OFF_DOUT_CTRL = 4'h7
    } reg_off_e;

    localparam logic [3:0] CHAN_BOARD = 4'h0;     // address bits 7..4
    localparam logic [3:0] REG_STATUS = 4'h0;     // offset on channel 0

    // ----------------------------------------
    // reset values and safety limits
    // ----------------------------------------
    localparam dac_t       DAC_MIDSCALE  = 16'h8000;
    localparam enc_count_t ENC_MIDRANGE  = 24'h800000;
    localparam dac_t       SAFETY_MARGIN = 16'h0400;
    localparam int         SAFETY_HOLD   = 4;     // consecutive over-limit cycles
    localparam int         SAFETY_CNT_W  = $clog2(SAFETY_HOLD + 1);

    // status word layout
    localparam int STAT_AMP_LSB  = 0;
    localparam int STAT_PWR_BIT  = 4;
    localparam int STAT_SAFE_LSB = 8;
    localparam int STAT_ID_LSB   = 24;

    // main space, channel axis+1, matching offset
    function automatic logic axis_hit(input addr_t a, input reg_off_e off, input int axis);
        return (a[15:12] == ADDR_MAIN) && (a[7:4] == 4'(axis + 1)) && (a[3:0] == off);
    endfunction

endpackage

// File: hw/host_bus_arbiter.sv
`timescale 1ns/1ns

module host_bus_arbiter (
    // firewire side
    input  logic           fw_reg_wen,
    input  qla_pkg::addr_t fw_reg_waddr,
    input  qla_pkg::data_t fw_reg_wdata,
    input  qla_pkg::addr_t fw_reg_raddr,
    // ethernet side
    input  logic           eth_reg_wen,
    input  qla_pkg::addr_t eth_reg_waddr,
    input  qla_pkg::data_t eth_reg_wdata,
    input  qla_pkg::addr_t eth_reg_raddr,
    input  logic           eth_read_en,     // eth owns the read address
    // internal register bus
    output logic           reg_wen,
    output qla_pkg::addr_t reg_waddr,
    output qla_pkg::data_t reg_wdata,
    output qla_pkg::addr_t reg_raddr
);

    // ----------------------------------------
    // write side, ethernet wins
    // ----------------------------------------
    // a same-cycle fw write still raises the strobe
    // but lands at the eth address with eth data
    assign reg_wen   = fw_reg_wen | eth_reg_wen;
    assign reg_waddr = eth_reg_wen ? eth_reg_waddr : fw_reg_waddr;
    assign reg_wdata = eth_reg_wen ? eth_reg_wdata : fw_reg_wdata;

    // ----------------------------------------
    // read side
    // ----------------------------------------
    // fw is the default owner of the read address
    assign reg_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;

endmodule

// File: hw/axis_cmd_regs.sv
`timescale 1ns/1ns

module axis_cmd_regs (
    input  logic                                   sysclk,
    input  logic                                   rst_n,
    input  logic                                   reg_wen,
    input  qla_pkg::addr_t                         reg_waddr,
    input  qla_pkg::data_t                         reg_wdata,
    input  qla_pkg::addr_t                         reg_raddr,
    input  qla_pkg::dac_t [qla_pkg::NUM_AXES-1:0]  cur_fb,     // adc current feedback
    output qla_pkg::dac_t [qla_pkg::NUM_AXES-1:0]  cur_cmd,    // dac current command
    output logic          [qla_pkg::NUM_AXES-1:0]  dout,
    output qla_pkg::data_t                         reg_rdata
);

    logic [qla_pkg::NUM_AXES-1:0] dac_wr;    // per-axis write hits
    logic [qla_pkg::NUM_AXES-1:0] dout_wr;

    // ----------------------------------------
    // write decode
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            dac_wr[i]  = reg_wen && qla_pkg::axis_hit(reg_waddr, qla_pkg::OFF_DAC_CTRL, i);
            dout_wr[i] = reg_wen && qla_pkg::axis_hit(reg_waddr, qla_pkg::OFF_DOUT_CTRL, i);
        end
    end

    // command and dout registers
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                cur_cmd[i] <= qla_pkg::DAC_MIDSCALE;    // zero current
            end
            dout <= '0;
        end else begin
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                if (dac_wr[i]) begin
                    cur_cmd[i] <= reg_wdata[15:0];
                end
                if (dout_wr[i]) begin
                    dout[i] <= reg_wdata[0];
                end
            end
        end
    end

    // ----------------------------------------
    // read-back, zero when no hit
    // ----------------------------------------
    always_comb begin
        reg_rdata = '0;
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            if (qla_pkg::axis_hit(reg_raddr, qla_pkg::OFF_DAC_CTRL, i)) begin
                reg_rdata = {16'd0, cur_cmd[i]};
            end
            if (qla_pkg::axis_hit(reg_raddr, qla_pkg::OFF_DOUT_CTRL, i)) begin
                reg_rdata = {31'd0, dout[i]};
            end
            if (qla_pkg::axis_hit(reg_raddr, qla_pkg::OFF_ADC_DATA, i)) begin
                reg_rdata = {16'd0, cur_fb[i]};  // upper half was pot feedback
            end
        end
    end

endmodule

// File: hw/quad_encoder.sv
`timescale 1ns/1ns

module quad_encoder (
    input  logic                         sysclk,
    input  logic                         rst_n,
    input  logic [qla_pkg::NUM_AXES-1:0] enc_a,
    input  logic [qla_pkg::NUM_AXES-1:0] enc_b,
    input  logic                         reg_wen,
    input  qla_pkg::addr_t               reg_waddr,
    input  qla_pkg::data_t               reg_wdata,
    input  qla_pkg::addr_t               reg_raddr,
    output qla_pkg::data_t               reg_rdata
);

    logic [qla_pkg::NUM_AXES-1:0] a_meta, b_meta;    // first sync stage
    logic [qla_pkg::NUM_AXES-1:0] a_sync, b_sync;    // second sync stage
    logic [qla_pkg::NUM_AXES-1:0] a_prev, b_prev;    // last decoded phase
    logic [qla_pkg::NUM_AXES-1:0] step;              // exactly one input moved
    logic [qla_pkg::NUM_AXES-1:0] step_up;
    logic [qla_pkg::NUM_AXES-1:0] load;

    qla_pkg::enc_count_t [qla_pkg::NUM_AXES-1:0] count;
    qla_pkg::enc_count_t [qla_pkg::NUM_AXES-1:0] preload;

    // ----------------------------------------
    // input sync, 2 flops plus phase history
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        a_meta <= enc_a;
        b_meta <= enc_b;
        a_sync <= a_meta;
        b_sync <= b_meta;
        a_prev <= a_sync;
        b_prev <= b_sync;
    end

    // x4 decode, 00 10 11 01 counts up
    assign step    = (a_sync ^ a_prev) ^ (b_sync ^ b_prev);  // both moving cancels out
    assign step_up = a_sync ^ b_prev;

    always_comb begin
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            load[i] = reg_wen && qla_pkg::axis_hit(reg_waddr, qla_pkg::OFF_ENC_LOAD, i);
        end
    end

    // counters, preload write wins over a step
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                count[i]   <= qla_pkg::ENC_MIDRANGE;
                preload[i] <= qla_pkg::ENC_MIDRANGE;
            end
        end else begin
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                if (load[i]) begin
                    preload[i] <= reg_wdata[qla_pkg::ENC_WIDTH-1:0];
                    count[i]   <= reg_wdata[qla_pkg::ENC_WIDTH-1:0];
                end else if (step[i]) begin
                    count[i] <= step_up[i] ? count[i] + 1'b1 : count[i] - 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // read-back, zero extended
    // ----------------------------------------
    always_comb begin
        reg_rdata = '0;
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            if (qla_pkg::axis_hit(reg_raddr, qla_pkg::OFF_ENC_LOAD, i)) begin
                reg_rdata = qla_pkg::data_t'(preload[i]);
            end
            if (qla_pkg::axis_hit(reg_raddr, qla_pkg::OFF_ENC_DATA, i)) begin
                reg_rdata = qla_pkg::data_t'(count[i]);
            end
        end
    end

endmodule

// File: hw/current_safety.sv
`timescale 1ns/1ns

module current_safety (
    input  logic                                  sysclk,
    input  logic                                  rst_n,
    input  qla_pkg::dac_t [qla_pkg::NUM_AXES-1:0] cur_fb,
    input  qla_pkg::dac_t [qla_pkg::NUM_AXES-1:0] cur_cmd,
    input  logic          [qla_pkg::NUM_AXES-1:0] clear_disable,   // one-cycle pulse
    output logic          [qla_pkg::NUM_AXES-1:0] safety_disable
);

    logic [qla_pkg::NUM_AXES-1:0] over_now;    // comparator output
    logic [qla_pkg::NUM_AXES-1:0] over_q;      // registered compare
    logic [qla_pkg::SAFETY_CNT_W-1:0] hold_cnt [qla_pkg::NUM_AXES];

    // distance from midscale, either direction
    function automatic qla_pkg::dac_t magnitude(input qla_pkg::dac_t v);
        return (v >= qla_pkg::DAC_MIDSCALE) ? v - qla_pkg::DAC_MIDSCALE
                                            : qla_pkg::DAC_MIDSCALE - v;
    endfunction

    // ----------------------------------------
    // |fb| > 2*|cmd| + margin
    // ----------------------------------------
    always_comb begin
        logic [17:0] limit;
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            limit       = {1'b0, magnitude(cur_cmd[i]), 1'b0} + 18'(qla_pkg::SAFETY_MARGIN);
            over_now[i] = 18'(magnitude(cur_fb[i])) > limit;
        end
    end

    // persistence filter and latched disable
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            over_q         <= '0;
            safety_disable <= '0;
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                hold_cnt[i] <= '0;
            end
        end else begin
            over_q <= over_now;
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                if (clear_disable[i]) begin
                    safety_disable[i] <= 1'b0;    // restart the filter too
                    hold_cnt[i]       <= '0;
                end else if (!over_q[i]) begin
                    hold_cnt[i] <= '0;            // disable stays latched
                end else if (hold_cnt[i] == qla_pkg::SAFETY_CNT_W'(qla_pkg::SAFETY_HOLD - 1)) begin
                    safety_disable[i] <= 1'b1;
                end else begin
                    hold_cnt[i] <= hold_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/board_regs.sv
`timescale 1ns/1ns

module board_regs (
    input  logic                         sysclk,
    input  logic                         rst_n,
    input  logic [3:0]                   wenid,            // rotary switch, active low
    input  logic [qla_pkg::NUM_AXES-1:0] safety_disable,
    input  logic                         reg_wen,
    input  qla_pkg::addr_t               reg_waddr,
    input  qla_pkg::data_t               reg_wdata,
    input  qla_pkg::addr_t               reg_raddr,
    output logic [qla_pkg::NUM_AXES-1:0] amp_en,
    output logic                         pwr_en,
    output logic [qla_pkg::NUM_AXES-1:0] clear_disable,
    output qla_pkg::data_t               reg_rdata
);

    logic                         status_wr;
    logic                         status_rd;
    logic [qla_pkg::NUM_AXES-1:0] amp_req;       // requested enables as written
    logic [qla_pkg::NUM_AXES-1:0] wr_amp_bits;
    qla_pkg::data_t               status_word;

    // ----------------------------------------
    // channel 0 decode
    // ----------------------------------------
    assign status_wr = reg_wen && (reg_waddr[15:12] == qla_pkg::ADDR_MAIN)
                    && (reg_waddr[7:4] == qla_pkg::CHAN_BOARD)
                    && (reg_waddr[3:0] == qla_pkg::REG_STATUS);
    assign status_rd = (reg_raddr[15:12] == qla_pkg::ADDR_MAIN)
                    && (reg_raddr[7:4] == qla_pkg::CHAN_BOARD)
                    && (reg_raddr[3:0] == qla_pkg::REG_STATUS);

    assign wr_amp_bits = reg_wdata[qla_pkg::STAT_AMP_LSB +: qla_pkg::NUM_AXES];

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_req <= '0;
            pwr_en  <= 1'b0;
        end else if (status_wr) begin
            amp_req <= wr_amp_bits;
            pwr_en  <= reg_wdata[qla_pkg::STAT_PWR_BIT];
        end
    end

    // pwr bit clears every axis, amp bit only its own
    assign clear_disable = status_wr
        ? ({qla_pkg::NUM_AXES{reg_wdata[qla_pkg::STAT_PWR_BIT]}} | wr_amp_bits) : '0;

    assign amp_en = amp_req & {qla_pkg::NUM_AXES{pwr_en}} & ~safety_disable;

    // ----------------------------------------
    // status read-back
    // ----------------------------------------
    always_comb begin
        status_word = '0;
        status_word[qla_pkg::STAT_ID_LSB +: 4]                  = ~wenid;    // board id
        status_word[qla_pkg::STAT_SAFE_LSB +: qla_pkg::NUM_AXES] = safety_disable;
        status_word[qla_pkg::STAT_PWR_BIT]                      = pwr_en;
        status_word[qla_pkg::STAT_AMP_LSB +: qla_pkg::NUM_AXES]  = amp_req;
    end

    assign reg_rdata = status_rd ? status_word : '0;

endmodule

// File: hw/qla_ctrl_top.sv
`timescale 1ns/1ns

module qla_ctrl_top (
    input  logic                                  sysclk,
    input  logic                                  rst_n,
    // host ports
    input  logic                                  fw_reg_wen,
    input  qla_pkg::addr_t                        fw_reg_waddr,
    input  qla_pkg::data_t                        fw_reg_wdata,
    input  qla_pkg::addr_t                        fw_reg_raddr,
    input  logic                                  eth_reg_wen,
    input  qla_pkg::addr_t                        eth_reg_waddr,
    input  qla_pkg::data_t                        eth_reg_wdata,
    input  qla_pkg::addr_t                        eth_reg_raddr,
    input  logic                                  eth_read_en,
    // board i/o
    input  logic          [3:0]                   wenid,
    input  logic          [qla_pkg::NUM_AXES-1:0] enc_a,
    input  logic          [qla_pkg::NUM_AXES-1:0] enc_b,
    input  qla_pkg::dac_t [qla_pkg::NUM_AXES-1:0] cur_fb,
    output qla_pkg::data_t                        reg_rdata,
    output qla_pkg::dac_t [qla_pkg::NUM_AXES-1:0] dac_cmd,
    output logic          [qla_pkg::NUM_AXES-1:0] dout,
    output logic          [qla_pkg::NUM_AXES-1:0] amp_en,
    output logic                                  pwr_en
);

    // ----------------------------------------
    // internal bus and cross-module wires
    // ----------------------------------------
    logic                         reg_wen;
    qla_pkg::addr_t               reg_waddr;
    qla_pkg::data_t               reg_wdata;
    qla_pkg::addr_t               reg_raddr;
    qla_pkg::data_t               rdata_axis;       // dac, dout, adc
    qla_pkg::data_t               rdata_enc;
    qla_pkg::data_t               rdata_board;      // channel 0
    logic [qla_pkg::NUM_AXES-1:0] safety_disable;
    logic [qla_pkg::NUM_AXES-1:0] clear_disable;

    host_bus_arbiter u_arb (
        .fw_reg_wen, .fw_reg_waddr, .fw_reg_wdata, .fw_reg_raddr,
        .eth_reg_wen, .eth_reg_waddr, .eth_reg_wdata, .eth_reg_raddr, .eth_read_en,
        .reg_wen, .reg_waddr, .reg_wdata, .reg_raddr
    );

    axis_cmd_regs u_cmd (
        .sysclk, .rst_n, .reg_wen, .reg_waddr, .reg_wdata, .reg_raddr,
        .cur_fb, .cur_cmd(dac_cmd), .dout, .reg_rdata(rdata_axis)
    );

    quad_encoder u_enc (
        .sysclk, .rst_n, .enc_a, .enc_b,
        .reg_wen, .reg_waddr, .reg_wdata, .reg_raddr, .reg_rdata(rdata_enc)
    );

    current_safety u_safe (
        .sysclk, .rst_n, .cur_fb, .cur_cmd(dac_cmd), .clear_disable, .safety_disable
    );

    board_regs u_chan0 (
        .sysclk, .rst_n, .wenid, .safety_disable,
        .reg_wen, .reg_waddr, .reg_wdata, .reg_raddr,
        .amp_en, .pwr_en, .clear_disable, .reg_rdata(rdata_board)
    );

    // leaves return zero on a miss, other spaces read 0
    assign reg_rdata = rdata_axis | rdata_enc | rdata_board;

endmodule

// File: tests/tb_qla_ctrl.sv
`timescale 1ns/1ns

module tb_qla_ctrl;

    typedef enum int {
        ACT_FW_WR, ACT_ETH_WR, ACT_BOTH_WR, ACT_RD_FW, ACT_RD_ETH, ACT_ENC,
        ACT_FB, ACT_WAIT, ACT_CHK_AMP, ACT_CHK_PWR, ACT_CHK_DOUT, ACT_CHK_DAC
    } act_e;

    localparam logic [3:0]  BOARD_SW   = 4'b1010;   // wenid straps, id reads 4'b0101
    localparam logic [15:0] IDLE_RADDR = 16'h0000;  // status, never reads zero

    logic sysclk;
    logic rst_n;
    logic fw_reg_wen, eth_reg_wen, eth_read_en;
    qla_pkg::addr_t fw_reg_waddr, fw_reg_raddr, eth_reg_waddr, eth_reg_raddr;
    qla_pkg::data_t fw_reg_wdata, eth_reg_wdata, reg_rdata;
    logic [3:0] wenid;
    logic [qla_pkg::NUM_AXES-1:0] enc_a, enc_b, dout, amp_en;
    logic pwr_en;
    qla_pkg::dac_t [qla_pkg::NUM_AXES-1:0] cur_fb, dac_cmd;

    // stimulus table, one column per queue
    string       t_name[$];
    act_e        t_act[$];
    logic [15:0] t_addr[$];
    logic [31:0] t_data[$];
    logic [31:0] t_exp[$];     // fw address on a simultaneous write

    int          errors;
    int          checks;
    int          cycle_count;
    int          timeout_limit;
    logic [31:0] lcg_state;

    qla_ctrl_top dut (.*);

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    always @(posedge sysclk) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] reg_addr(input int chan, input logic [3:0] off);
        return {qla_pkg::ADDR_MAIN, 4'h0, 4'(chan), off};
    endfunction

    // id 27..24, disables 11..8, power 4, amps 3..0
    function automatic logic [31:0] status_val(input logic [3:0] amp, input logic pwr,
                                               input logic [3:0] safe);
        return {4'h0, ~BOARD_SW, 12'h000, safe, 3'b000, pwr, amp};
    endfunction

    function automatic void add_entry(input string name, input act_e act,
                                      input logic [15:0] addr, input logic [31:0] data,
                                      input logic [31:0] exp);
        t_name.push_back(name);
        t_act.push_back(act);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_exp.push_back(exp);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [15:0] cmd_model [4];
        logic [23:0] pre;
        logic [1:0]  seq_up [4];
        int          pos;
        act_e        wr_act;
        seq_up = '{2'b10, 2'b11, 2'b01, 2'b00};   // {a,b} in counting-up order
        // ----------------------------------------
        // reset values
        for (int ch = 1; ch <= 4; ch++) begin
            cmd_model[ch-1] = qla_pkg::DAC_MIDSCALE;
            add_entry($sformatf("rst_dac_ch%0d", ch), ACT_RD_FW,
                      reg_addr(ch, qla_pkg::OFF_DAC_CTRL), 0, 32'h0000_8000);
            add_entry($sformatf("rst_enc_ch%0d", ch), ACT_RD_ETH,
                      reg_addr(ch, qla_pkg::OFF_ENC_DATA), 0, 32'h0080_0000);
            add_entry($sformatf("rst_adc_ch%0d", ch), ACT_RD_FW,
                      reg_addr(ch, qla_pkg::OFF_ADC_DATA), 0, 32'h0000_8000);
            add_entry($sformatf("rst_dac_port%0d", ch), ACT_CHK_DAC, 16'(ch - 1), 0, 32'h8000);
        end
        add_entry("rst_status", ACT_RD_FW, IDLE_RADDR, 0, status_val(4'h0, 1'b0, 4'h0));
        add_entry("rst_amp_en", ACT_CHK_AMP, 0, 0, 0);
        add_entry("rst_pwr_en", ACT_CHK_PWR, 0, 0, 0);
        add_entry("rst_dout", ACT_CHK_DOUT, 0, 0, 0);
        add_entry("prom_zero", ACT_RD_FW, 16'h2011, 0, 0);    // unmapped space
        // ----------------------------------------
        // host writes, odd channels fw, even eth
        for (int ch = 1; ch <= 4; ch++) begin
            r = next_random();
            cmd_model[ch-1] = r[15:0];
            if (ch % 2 == 1) begin
                wr_act = ACT_FW_WR;
            end else begin
                wr_act = ACT_ETH_WR;
            end
            add_entry($sformatf("wr_dac_ch%0d", ch), wr_act,
                      reg_addr(ch, qla_pkg::OFF_DAC_CTRL), r, 0);
            add_entry($sformatf("rd_fw_dac_ch%0d", ch), ACT_RD_FW,
                      reg_addr(ch, qla_pkg::OFF_DAC_CTRL), 0, {16'h0, r[15:0]});
            add_entry($sformatf("rd_eth_dac_ch%0d", ch), ACT_RD_ETH,
                      reg_addr(ch, qla_pkg::OFF_DAC_CTRL), 0, {16'h0, r[15:0]});
            add_entry($sformatf("dac_port%0d", ch), ACT_CHK_DAC, 16'(ch - 1), 0, {16'h0, r[15:0]});
        end
        r = next_random();
        add_entry("both_wr", ACT_BOTH_WR, reg_addr(1, qla_pkg::OFF_DAC_CTRL), r,
                  {16'h0, reg_addr(3, qla_pkg::OFF_DAC_CTRL)});
        cmd_model[0] = r[15:0];                        // eth lands, ch3 untouched
        add_entry("both_eth_lands", ACT_RD_FW, reg_addr(1, qla_pkg::OFF_DAC_CTRL), 0,
                  {16'h0, cmd_model[0]});
        add_entry("both_fw_dropped", ACT_RD_ETH, reg_addr(3, qla_pkg::OFF_DAC_CTRL), 0,
                  {16'h0, cmd_model[2]});
        add_entry("both_fw_port", ACT_CHK_DAC, 2, 0, {16'h0, cmd_model[2]});
        // ----------------------------------------
        // encoder on channel 2
        r = next_random();
        pre = r[23:0];
        add_entry("enc_preload", ACT_ETH_WR, reg_addr(2, qla_pkg::OFF_ENC_LOAD), r, 0);
        add_entry("enc_count_loaded", ACT_RD_FW, reg_addr(2, qla_pkg::OFF_ENC_DATA), 0,
                  {8'h0, pre});
        add_entry("enc_preload_rd", ACT_RD_ETH, reg_addr(2, qla_pkg::OFF_ENC_LOAD), 0,
                  {8'h0, pre});
        pos = 3;                                       // phase 00
        for (int i = 0; i < 6; i++) begin
            pos = (pos + 1) % 4;
            add_entry($sformatf("enc_fwd%0d", i), ACT_ENC, 1, {30'h0, seq_up[pos]}, 0);
        end
        add_entry("enc_up6", ACT_RD_FW, reg_addr(2, qla_pkg::OFF_ENC_DATA), 0,
                  {8'h0, pre + 24'd6});
        for (int i = 0; i < 6; i++) begin
            pos = (pos + 3) % 4;
            add_entry($sformatf("enc_back%0d", i), ACT_ENC, 1, {30'h0, seq_up[pos]}, 0);
        end
        add_entry("enc_restored", ACT_RD_FW, reg_addr(2, qla_pkg::OFF_ENC_DATA), 0,
                  {8'h0, pre});
        // ----------------------------------------
        // digital outputs and enables
        add_entry("dout_ch1_on", ACT_FW_WR, reg_addr(1, qla_pkg::OFF_DOUT_CTRL), 1, 0);
        add_entry("dout_ch3_on", ACT_ETH_WR, reg_addr(3, qla_pkg::OFF_DOUT_CTRL), 1, 0);
        add_entry("dout_port", ACT_CHK_DOUT, 0, 0, 32'h5);
        add_entry("dout_rd_ch3", ACT_RD_FW, reg_addr(3, qla_pkg::OFF_DOUT_CTRL), 0, 1);
        add_entry("dout_rd_ch2", ACT_RD_FW, reg_addr(2, qla_pkg::OFF_DOUT_CTRL), 0, 0);
        add_entry("dout_ch1_off", ACT_ETH_WR, reg_addr(1, qla_pkg::OFF_DOUT_CTRL),
                  32'hffff_fffe, 0);                   // only bit 0 counts
        add_entry("dout_port2", ACT_CHK_DOUT, 0, 0, 32'h4);
        add_entry("amp_no_pwr", ACT_FW_WR, IDLE_RADDR, 32'h0f, 0);
        add_entry("amp_no_pwr_port", ACT_CHK_AMP, 0, 0, 0);
        add_entry("pwr_off_port", ACT_CHK_PWR, 0, 0, 0);
        add_entry("status_no_pwr", ACT_RD_FW, IDLE_RADDR, 0, status_val(4'hf, 1'b0, 4'h0));
        add_entry("amp_pwr", ACT_ETH_WR, IDLE_RADDR, 32'h1f, 0);
        add_entry("amp_pwr_port", ACT_CHK_AMP, 0, 0, 32'hf);
        add_entry("pwr_on_port", ACT_CHK_PWR, 0, 0, 1);
        add_entry("status_pwr", ACT_RD_ETH, IDLE_RADDR, 0, status_val(4'hf, 1'b1, 4'h0));
        add_entry("amp_pwr_drop", ACT_FW_WR, IDLE_RADDR, 32'h05, 0);
        add_entry("amp_pwr_drop_port", ACT_CHK_AMP, 0, 0, 0);
        add_entry("amp_pwr_again", ACT_FW_WR, IDLE_RADDR, 32'h1f, 0);
        add_entry("amp_pwr_again_port", ACT_CHK_AMP, 0, 0, 32'hf);
        // ----------------------------------------
        // overcurrent on channel 2, limit 2*0x100+0x400
        add_entry("safe_cmd", ACT_ETH_WR, reg_addr(2, qla_pkg::OFF_DAC_CTRL), 32'h8100, 0);
        add_entry("safe_fb_high", ACT_FB, 1, 32'h9000, 0);
        add_entry("safe_hold", ACT_WAIT, 0, 10, 0);
        add_entry("safe_trip_port", ACT_CHK_AMP, 0, 0, 32'hd);
        add_entry("safe_trip_status", ACT_RD_FW, IDLE_RADDR, 0, status_val(4'hf, 1'b1, 4'h2));
        add_entry("safe_adc_rd", ACT_RD_ETH, reg_addr(2, qla_pkg::OFF_ADC_DATA), 0,
                  32'h0000_9000);                      // feedback, not the command
        add_entry("safe_fb_low", ACT_FB, 1, 32'h8000, 0);
        add_entry("safe_settle", ACT_WAIT, 0, 2, 0);
        add_entry("safe_latched", ACT_CHK_AMP, 0, 0, 32'hd);
        add_entry("safe_rewrite", ACT_FW_WR, IDLE_RADDR, 32'h1f, 0);
        add_entry("safe_cleared_port", ACT_CHK_AMP, 0, 0, 32'hf);
        add_entry("safe_cleared_status", ACT_RD_ETH, IDLE_RADDR, 0,
                  status_val(4'hf, 1'b1, 4'h0));
    endtask

    // one table row, starting on a falling edge
    task automatic run_entry(input int k);
        @(negedge sysclk);
        fw_reg_wen  = 1'b0;                    // strobes last one cycle
        eth_reg_wen = 1'b0;
        case (t_act[k])
            ACT_FW_WR: begin
                fw_reg_wen   = 1'b1;
                fw_reg_waddr = t_addr[k];
                fw_reg_wdata = t_data[k];
            end
            ACT_ETH_WR, ACT_BOTH_WR: begin
                eth_reg_wen   = 1'b1;
                eth_reg_waddr = t_addr[k];
                eth_reg_wdata = t_data[k];
                if (t_act[k] == ACT_BOTH_WR) begin
                    fw_reg_wen   = 1'b1;
                    fw_reg_waddr = t_exp[k][15:0];
                    fw_reg_wdata = ~t_data[k];
                end
            end
            ACT_RD_FW, ACT_RD_ETH: begin
                eth_read_en   = (t_act[k] == ACT_RD_ETH);
                fw_reg_raddr  = eth_read_en ? IDLE_RADDR : t_addr[k];
                eth_reg_raddr = eth_read_en ? t_addr[k] : IDLE_RADDR;
                #1;
                check_value(t_name[k], t_exp[k], reg_rdata);
            end
            ACT_ENC: begin
                enc_a[t_addr[k]] = t_data[k][1];
                enc_b[t_addr[k]] = t_data[k][0];
                repeat (3) @(negedge sysclk);  // 4 cycles per phase
            end
            ACT_FB: cur_fb[t_addr[k]] = t_data[k][15:0];
            ACT_WAIT: repeat (t_data[k]) @(negedge sysclk);
            ACT_CHK_AMP: begin
                #1;
                check_value(t_name[k], t_exp[k], 32'(amp_en));
            end
            ACT_CHK_PWR: begin
                #1;
                check_value(t_name[k], t_exp[k], 32'(pwr_en));
            end
            ACT_CHK_DOUT: begin
                #1;
                check_value(t_name[k], t_exp[k], 32'(dout));
            end
            ACT_CHK_DAC: begin
                #1;
                check_value(t_name[k], t_exp[k], 32'(dac_cmd[t_addr[k]]));
            end
            default: ;
        endcase
    endtask

    // ----------------------------------------
    // main sequence
    initial begin
        errors        = 0;
        checks        = 0;
        timeout_limit = 0;
        lcg_state     = 32'h8c17_25af;
        rst_n         = 1'b0;
        fw_reg_wen    = 1'b0;
        fw_reg_waddr  = '0;
        fw_reg_wdata  = '0;
        fw_reg_raddr  = IDLE_RADDR;
        eth_reg_wen   = 1'b0;
        eth_reg_waddr = '0;
        eth_reg_wdata = '0;
        eth_reg_raddr = IDLE_RADDR;
        eth_read_en   = 1'b0;
        wenid         = BOARD_SW;
        enc_a         = '0;
        enc_b         = '0;
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            cur_fb[i] = qla_pkg::DAC_MIDSCALE;  // zero current
        end
        build_table();
        timeout_limit = 20 * t_act.size() + 8;
        repeat (8) @(posedge sysclk);           // 8 rising edges in reset
        @(negedge sysclk);
        rst_n = 1'b1;
        for (int k = 0; k < t_act.size(); k++) begin
            run_entry(k);
        end
        @(negedge sysclk);
        fw_reg_wen  = 1'b0;
        eth_reg_wen = 1'b0;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (timeout_limit > 0);
        wait (cycle_count >= timeout_limit);
        $display("timeout: run did not finish within %0d cycles, errors so far %0d",
                 timeout_limit, errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: qla_ctrl_top.f
hw/qla_pkg.sv
hw/host_bus_arbiter.sv
hw/axis_cmd_regs.sv
hw/quad_encoder.sv
hw/current_safety.sv
hw/board_regs.sv
hw/qla_ctrl_top.sv
tests/tb_qla_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the qla_ctrl_top testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -Wno-fatal --top-module tb_qla_ctrl -Mdir obj_dir -f qla_ctrl_top.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_qla_ctrl > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the log decides the result
if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
